// ==== project.f ====
+incdir+include
hdl/stream_source_pkg.sv
hdl/source_addressgen.sv
hdl/tcdm_port_capture.sv
hdl/stream_merge.sv
hdl/stream_source_ctrl.sv
hdl/stream_source.sv
test/tcdm_mem_model.sv
test/tb_stream_source.sv

// ==== Bender.yml ====
package:
  name: stream_source

export_include_dirs:
  - include

sources:
  - files:
      - hdl/stream_source_pkg.sv
      - hdl/source_addressgen.sv
      - hdl/tcdm_port_capture.sv
      - hdl/stream_merge.sv
      - hdl/stream_source_ctrl.sv
      - hdl/stream_source.sv
  - target: test
    files:
      - test/tcdm_mem_model.sv
      - test/tb_stream_source.sv

// ==== test/tb_stream_source.sv ====
/*
 * testbench for the memory-to-stream source
 * runs a table of strided transfers against the TCDM model with
 * random grant stalls and stream back-pressure, checking every beat
 */
`timescale 1ns/1ps
`default_nettype none

`include "source_params.svh"

module tb_stream_source;

  import stream_source_pkg::*;

  localparam logic [31:0] DATA_KEY = 32'h5a3c_0f96;
  localparam int          NROWS    = 6;
  localparam int          TIMEOUT  = 2000;  // cycles per wait
  localparam int          STEP     = `SRC_NB_PORTS * (`SRC_WORD_W / 8);

  logic                           clk;
  logic                           rst_n;
  logic                           start;
  tcdm_addr_t                     base_addr;
  logic [`SRC_CNT_W-1:0]          trans_size;
  logic [`SRC_CNT_W-1:0]          line_length;
  tcdm_addr_t                     line_stride;
  logic                           ready_start;
  logic                           done;
  logic [`SRC_NB_PORTS-1:0]       tcdm_req;
  tcdm_addr_t [`SRC_NB_PORTS-1:0] tcdm_add;
  logic [`SRC_NB_PORTS-1:0]       tcdm_gnt;
  tcdm_word_t [`SRC_NB_PORTS-1:0] tcdm_r_data;
  logic [`SRC_NB_PORTS-1:0]       tcdm_r_valid;
  logic                           stream_valid;
  logic [`SRC_STREAM_W-1:0]       stream_data;
  logic                           stream_ready;
  logic [`SRC_NB_PORTS-1:0]       stall;
  logic                           mem_clr;
  int unsigned                    acc_total;
  int unsigned                    dup_cnt;

  // fields base, trans_size, line_length, stride, stall %, back-pressure %
  logic [95:0]              table_q [NROWS];
  logic [`SRC_STREAM_W-1:0] exp_q [$];
  logic [`SRC_STREAM_W-1:0] exp_beat;
  logic [`SRC_STREAM_W-1:0] hold_data;
  logic                     hold_pending;
  logic [31:0]              rng;
  int                       stall_pct;
  int                       bp_pct;
  int                       errors;
  int                       beats_checked;
  int                       done_cnt;

  stream_source u_dut (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .start_i        ( start        ),
    .base_addr_i    ( base_addr    ),
    .trans_size_i   ( trans_size   ),
    .line_length_i  ( line_length  ),
    .line_stride_i  ( line_stride  ),
    .ready_start_o  ( ready_start  ),
    .done_o         ( done         ),
    .tcdm_req_o     ( tcdm_req     ),
    .tcdm_add_o     ( tcdm_add     ),
    .tcdm_gnt_i     ( tcdm_gnt     ),
    .tcdm_r_data_i  ( tcdm_r_data  ),
    .tcdm_r_valid_i ( tcdm_r_valid ),
    .stream_valid_o ( stream_valid ),
    .stream_data_o  ( stream_data  ),
    .stream_ready_i ( stream_ready )
  );

  tcdm_mem_model #(
    .DATA_KEY ( DATA_KEY )
  ) u_mem (
    .clk_i       ( clk          ),
    .rst_ni      ( rst_n        ),
    .clr_i       ( mem_clr      ),
    .req_i       ( tcdm_req     ),
    .add_i       ( tcdm_add     ),
    .stall_i     ( stall        ),
    .gnt_o       ( tcdm_gnt     ),
    .r_data_o    ( tcdm_r_data  ),
    .r_valid_o   ( tcdm_r_valid ),
    .acc_total_o ( acc_total    ),
    .dup_cnt_o   ( dup_cnt      )
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic tcdm_word_t mem_word(input tcdm_addr_t a);
    return a ^ DATA_KEY;
  endfunction

  task automatic report_error(input string sig, input logic [63:0] exp_val,
                              input logic [63:0] act_val);
    errors++;
    $display("** Error at %0t: %s expected %h, got %h", $time, sig, exp_val, act_val);
  endtask

  always #5 clk = ~clk;

  // random grant stalls and back-pressure
  always @(posedge clk) begin
    for (int k = 0; k < `SRC_NB_PORTS; k++) begin
      rng = lcg_next(rng);
      stall[k] <= (rng[30:16] % 100) < stall_pct;
    end
    rng = lcg_next(rng);
    stream_ready <= (rng[30:16] % 100) >= bp_pct;
  end

  // stream sink and done monitor sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n) begin
      if (done) begin
        done_cnt++;
      end
      if (hold_pending) begin
        if (!stream_valid) begin
          errors++;
          $display("stream_valid_o dropped before its beat was taken at %0t", $time);
        end else if (stream_data !== hold_data) begin
          report_error("stream_data_o", hold_data, stream_data);
        end
      end
      if (stream_valid && stream_ready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("unexpected extra stream beat at %0t", $time);
        end else begin
          exp_beat = exp_q.pop_front();
          beats_checked++;
          if (stream_data !== exp_beat) begin
            report_error("stream_data_o", exp_beat, stream_data);
          end
        end
      end
      hold_pending = stream_valid && !stream_ready;
      hold_data    = stream_data;
    end
  end

  initial begin
    logic [95:0] row;
    int          wc;
    int          size;
    int          len;
    int          stride;
    int          done_base;
    tcdm_addr_t  addr;

    clk           = 1'b0;
    rst_n         = 1'b0;
    start         = 1'b0;
    base_addr     = '0;
    trans_size    = '0;
    line_length   = '0;
    line_stride   = '0;
    stream_ready  = 1'b0;
    stall         = '0;
    mem_clr       = 1'b0;
    rng           = 32'd87;
    stall_pct     = 0;
    bp_pct        = 0;
    errors        = 0;
    beats_checked = 0;
    done_cnt      = 0;
    hold_pending  = 1'b0;

    table_q[0] = {32'h0000_0100, 16'd8,  16'd8,  16'h0000, 8'd0,  8'd0};   // contiguous
    table_q[1] = {32'h0000_0400, 16'd12, 16'd3,  16'h0040, 8'd0,  8'd0};   // strided
    table_q[2] = {32'h0000_0800, 16'd16, 16'd4,  16'h0030, 8'd40, 8'd0};
    table_q[3] = {32'h0000_0c00, 16'd16, 16'd16, 16'h0000, 8'd0,  8'd50};
    table_q[4] = {32'h0000_1000, 16'd20, 16'd5,  16'h0040, 8'd30, 8'd30};
    table_q[5] = {32'h0000_2000, 16'd1,  16'd1,  16'h0008, 8'd50, 8'd50};

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (tcdm_req !== '0) report_error("tcdm_req_o", '0, tcdm_req);
    if (stream_valid !== 1'b0) report_error("stream_valid_o", 0, stream_valid);
    if (done !== 1'b0) report_error("done_o", 0, done);
    if (ready_start !== 1'b1) report_error("ready_start_o", 1, ready_start);

    for (int r = 0; r < NROWS; r++) begin
      row    = table_q[r];
      size   = row[63:48];
      len    = row[47:32];
      stride = row[31:16];
      wc     = 0;
      while (ready_start !== 1'b1 && wc < TIMEOUT) begin
        @(negedge clk);
        wc++;
      end
      if (ready_start !== 1'b1) begin
        errors++;
        $display("timed out waiting for ready_start_o before row %0d", r);
      end

      @(posedge clk);
      for (int i = 0; i < size; i++) begin
        addr = row[95:64] + (i / len) * stride + (i % len) * STEP;
        exp_q.push_back({mem_word(addr + 4), mem_word(addr)});  // port 0 in low lane
      end
      done_base   = done_cnt;
      base_addr   <= row[95:64];
      trans_size  <= size;
      line_length <= len;
      line_stride <= stride;
      stall_pct   <= row[15:8];
      bp_pct      <= row[7:0];
      mem_clr     <= 1'b1;
      start       <= 1'b1;
      @(posedge clk);
      start   <= 1'b0;
      mem_clr <= 1'b0;

      wc = 0;
      @(negedge clk);
      while (done !== 1'b1 && wc < TIMEOUT) begin
        if (ready_start !== 1'b0) report_error("ready_start_o", 0, ready_start);
        @(negedge clk);
        wc++;
      end
      if (done !== 1'b1) begin
        errors++;
        $display("timed out waiting for done_o in row %0d", r);
      end else if (acc_total != 2 * size) begin
        // every word must be granted by the time done_o fires
        report_error("accepted requests at done_o", 2 * size, acc_total);
      end

      wc = 0;
      while (exp_q.size() != 0 && wc < TIMEOUT) begin
        @(posedge clk);
        wc++;
      end
      if (exp_q.size() != 0) begin
        errors++;
        $display("row %0d ended with %0d beats missing", r, exp_q.size());
        exp_q.delete();
      end
      repeat (4) @(posedge clk);  // let stray beats show up
      @(negedge clk);
      if (done_cnt - done_base != 1) report_error("done_o pulses", 1, done_cnt - done_base);
      if (acc_total != 2 * size) report_error("accepted requests", 2 * size, acc_total);
      if (dup_cnt != 0) report_error("repeated requests", 0, dup_cnt);
    end

    $display("%0d beats checked, %0d errors", beats_checked, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/tcdm_mem_model.sv ====
/*
 * behavioral TCDM model
 * word content is the address xor a key, grants follow the stall inputs,
 * read data returns one cycle after each accepted request
 */
`timescale 1ns/1ps
`default_nettype none

`include "source_params.svh"

module tcdm_mem_model #(
  parameter logic [31:0] DATA_KEY = 32'h0
) (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  logic                                              clr_i,
  input  logic [`SRC_NB_PORTS-1:0]                          req_i,
  input  stream_source_pkg::tcdm_addr_t [`SRC_NB_PORTS-1:0] add_i,
  input  logic [`SRC_NB_PORTS-1:0]                          stall_i,
  output logic [`SRC_NB_PORTS-1:0]                          gnt_o,
  output stream_source_pkg::tcdm_word_t [`SRC_NB_PORTS-1:0] r_data_o,
  output logic [`SRC_NB_PORTS-1:0]                          r_valid_o,
  output int unsigned                                       acc_total_o,
  output int unsigned                                       dup_cnt_o
);

  import stream_source_pkg::*;

  localparam int unsigned SEEN_WORDS = 4096;  // covers byte addresses below 16 KiB

  logic        seen_q [SEEN_WORDS];
  logic [11:0] word_idx;

  assign gnt_o = ~stall_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_o <= '0;
      r_data_o  <= '0;
    end else begin
      for (int k = 0; k < `SRC_NB_PORTS; k++) begin
        r_valid_o[k] <= req_i[k] & gnt_o[k];
        if (req_i[k] && gnt_o[k]) begin
          r_data_o[k] <= add_i[k] ^ DATA_KEY;
        end
      end
    end
  end

  // accepted request bookkeeping, cleared per transfer
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni || clr_i) begin
      acc_total_o = 0;
      dup_cnt_o   = 0;
      for (int i = 0; i < SEEN_WORDS; i++) begin
        seen_q[i] = 1'b0;
      end
    end else begin
      for (int k = 0; k < `SRC_NB_PORTS; k++) begin
        if (req_i[k] && gnt_o[k]) begin
          word_idx    = add_i[k][13:2];
          acc_total_o = acc_total_o + 1;
          if (seen_q[word_idx]) begin
            dup_cnt_o = dup_cnt_o + 1;  // same word read twice
          end
          seen_q[word_idx] = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/stream_source.sv ====
/*
 * memory-to-stream source
 * reads strided word pairs from the TCDM and emits them
 * as 64-bit valid/ready stream beats
 */
`timescale 1ns/1ps
`default_nettype none

`include "source_params.svh"

module stream_source (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  // control
  input  logic                                              start_i,
  input  stream_source_pkg::tcdm_addr_t                     base_addr_i,
  input  logic [`SRC_CNT_W-1:0]                             trans_size_i,
  input  logic [`SRC_CNT_W-1:0]                             line_length_i,
  input  stream_source_pkg::tcdm_addr_t                     line_stride_i,
  output logic                                              ready_start_o,
  output logic                                              done_o,
  // TCDM ports
  output logic [`SRC_NB_PORTS-1:0]                          tcdm_req_o,
  output stream_source_pkg::tcdm_addr_t [`SRC_NB_PORTS-1:0] tcdm_add_o,
  input  logic [`SRC_NB_PORTS-1:0]                          tcdm_gnt_i,
  input  stream_source_pkg::tcdm_word_t [`SRC_NB_PORTS-1:0] tcdm_r_data_i,
  input  logic [`SRC_NB_PORTS-1:0]                          tcdm_r_valid_i,
  // stream out
  output logic                                              stream_valid_o,
  output logic [`SRC_STREAM_W-1:0]                          stream_data_o,
  input  logic                                              stream_ready_i
);

  import stream_source_pkg::*;

  logic       addr_en;
  logic       addr_clr;
  logic       in_progress;
  tcdm_addr_t gen_addr;

  logic [`SRC_NB_PORTS-1:0]       cap_valid;
  logic [`SRC_NB_PORTS-1:0]       cap_ready;
  tcdm_word_t [`SRC_NB_PORTS-1:0] cap_data;

  stream_source_ctrl u_ctrl (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .start_i        ( start_i        ),
    .stream_ready_i ( stream_ready_i ),
    .tcdm_gnt_i     ( tcdm_gnt_i     ),
    .in_progress_i  ( in_progress    ),
    .tcdm_req_o     ( tcdm_req_o     ),
    .addr_en_o      ( addr_en        ),
    .addr_clr_o     ( addr_clr       ),
    .ready_start_o  ( ready_start_o  ),
    .done_o         ( done_o         )
  );

  source_addressgen u_addressgen (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .enable_i      ( addr_en       ),
    .clear_i       ( addr_clr      ),
    .base_addr_i   ( base_addr_i   ),
    .trans_size_i  ( trans_size_i  ),
    .line_length_i ( line_length_i ),
    .line_stride_i ( line_stride_i ),
    .gen_addr_o    ( gen_addr      ),
    .in_progress_o ( in_progress   )
  );

  for (genvar k = 0; k < `SRC_NB_PORTS; k++) begin : g_port
    // port k reads word k of the beat
    assign tcdm_add_o[k] = gen_addr + tcdm_addr_t'(k * (`SRC_WORD_W / 8));

    tcdm_port_capture u_capture (
      .clk_i     ( clk_i             ),
      .rst_ni    ( rst_ni            ),
      .r_valid_i ( tcdm_r_valid_i[k] ),
      .r_data_i  ( tcdm_r_data_i[k]  ),
      .valid_o   ( cap_valid[k]      ),
      .data_o    ( cap_data[k]       ),
      .ready_i   ( cap_ready[k]      )
    );
  end

  stream_merge u_merge (
    .clk_i       ( clk_i          ),
    .rst_ni      ( rst_ni         ),
    .in_valid_i  ( cap_valid      ),
    .in_data_i   ( cap_data       ),
    .in_ready_o  ( cap_ready      ),
    .out_valid_o ( stream_valid_o ),
    .out_data_o  ( stream_data_o  ),
    .out_ready_i ( stream_ready_i )
  );

endmodule

`default_nettype wire

// ==== hdl/stream_source_ctrl.sv ====
/*
 * stream source controller
 * idle/working FSM, per-port grant fence and TCDM request generation
 */
`timescale 1ns/1ps
`default_nettype none

`include "source_params.svh"

module stream_source_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     start_i,
  input  logic                     stream_ready_i,
  input  logic [`SRC_NB_PORTS-1:0] tcdm_gnt_i,
  input  logic                     in_progress_i,
  output logic [`SRC_NB_PORTS-1:0] tcdm_req_o,
  output logic                     addr_en_o,
  output logic                     addr_clr_o,
  output logic                     ready_start_o,
  output logic                     done_o
);

  import stream_source_pkg::*;

  source_state_e state_q;
  source_state_e state_d;

  logic [`SRC_NB_PORTS-1:0] fence_q;  // ports already granted this beat
  logic [`SRC_NB_PORTS-1:0] eff_gnt;
  logic                     issue;
  logic                     beat_done;

  // no requests while the stream is stalled
  assign issue      = (state_q == SRC_WORKING) & in_progress_i & stream_ready_i;
  assign tcdm_req_o = {`SRC_NB_PORTS{issue}} & ~fence_q;
  assign eff_gnt    = (tcdm_req_o & tcdm_gnt_i) | fence_q;
  assign beat_done  = issue & (&eff_gnt);
  assign addr_en_o  = beat_done;

  assign ready_start_o = (state_q == SRC_IDLE);
  assign done_o        = (state_q == SRC_WORKING) & ~in_progress_i;  // last beat granted
  assign addr_clr_o    = (ready_start_o & start_i) | done_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      SRC_IDLE: begin
        if (start_i) begin
          state_d = SRC_WORKING;
        end
      end
      SRC_WORKING: begin
        if (!in_progress_i) begin
          state_d = SRC_IDLE;
        end
      end
      default: state_d = SRC_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SRC_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fence_q <= '0;
    end else if (beat_done) begin
      fence_q <= '0;
    end else begin
      fence_q <= fence_q | (tcdm_req_o & tcdm_gnt_i);
    end
  end

endmodule

`default_nettype wire

// ==== hdl/stream_merge.sv ====
/*
 * stream merge
 * joins the per-port word streams into one wide beat,
 * port k in lane k, once every port holds a valid word
 */
`timescale 1ns/1ps
`default_nettype none

`include "source_params.svh"

module stream_merge (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  input  logic [`SRC_NB_PORTS-1:0]                         in_valid_i,
  input  stream_source_pkg::tcdm_word_t [`SRC_NB_PORTS-1:0] in_data_i,
  output logic [`SRC_NB_PORTS-1:0]                         in_ready_o,
  output logic                                             out_valid_o,
  output logic [`SRC_STREAM_W-1:0]                         out_data_o,
  input  logic                                             out_ready_i
);

  logic beat_taken;

  assign out_valid_o = &in_valid_i;
  assign out_data_o  = in_data_i;  // lane k is word k
  assign beat_taken  = out_valid_o & out_ready_i;
  assign in_ready_o  = {`SRC_NB_PORTS{beat_taken}};

  // beat must hold while stalled, relies on capture paths and request gating
  a_data_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (out_valid_o && !out_ready_i) |=> $stable(out_data_o)
  );

endmodule

`default_nettype wire

// ==== hdl/tcdm_port_capture.sv ====
/*
 * TCDM response capture
 * forwards a live response, or holds it for a later beat
 * when the merge does not take it in its arrival cycle
 */
`timescale 1ns/1ps
`default_nettype none

`include "source_params.svh"

module tcdm_port_capture (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          r_valid_i,
  input  stream_source_pkg::tcdm_word_t r_data_i,
  output logic                          valid_o,
  output stream_source_pkg::tcdm_word_t data_o,
  input  logic                          ready_i
);

  import stream_source_pkg::*;

  logic       hold_q;
  tcdm_word_t hold_data_q;

  assign valid_o = r_valid_i | hold_q;
  assign data_o  = r_valid_i ? r_data_i : hold_data_q;  // live word wins

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_q <= 1'b0;
    end else if (ready_i) begin
      hold_q <= 1'b0;
    end else if (r_valid_i) begin
      hold_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (r_valid_i) begin
      hold_data_q <= r_data_i;
    end
  end

  // requests are only issued when the stream can drain the held word
  a_no_overrun : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(r_valid_i && hold_q)
  );

endmodule

`default_nettype wire

// ==== hdl/source_addressgen.sv ====
/*
 * strided address generator
 * steps one beat per enable through lines of line_length beats,
 * jumping the line base by line_stride bytes at each line end
 */
`timescale 1ns/1ps
`default_nettype none

`include "source_params.svh"

module source_addressgen (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               enable_i,
  input  logic                               clear_i,
  input  stream_source_pkg::tcdm_addr_t      base_addr_i,
  input  logic [`SRC_CNT_W-1:0]              trans_size_i,
  input  logic [`SRC_CNT_W-1:0]              line_length_i,
  input  stream_source_pkg::tcdm_addr_t      line_stride_i,
  output stream_source_pkg::tcdm_addr_t      gen_addr_o,
  output logic                               in_progress_o
);

  import stream_source_pkg::*;

  // bytes per beat
  localparam int unsigned STEP = `SRC_NB_PORTS * (`SRC_WORD_W / 8);

  logic [`SRC_CNT_W-1:0] word_cnt_q;   // beat index inside the line
  logic [`SRC_CNT_W-1:0] total_cnt_q;  // beats issued so far
  logic [`SRC_CNT_W-1:0] word_cnt_nxt;
  tcdm_addr_t            line_base_q;
  tcdm_addr_t            line_offset;

  assign word_cnt_nxt  = word_cnt_q + 1'b1;
  assign line_offset   = tcdm_addr_t'(word_cnt_q) * tcdm_addr_t'(STEP);
  assign gen_addr_o    = line_base_q + line_offset;
  assign in_progress_o = total_cnt_q < trans_size_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_cnt_q  <= '0;
      total_cnt_q <= '0;
      line_base_q <= '0;
    end else if (clear_i) begin
      word_cnt_q  <= '0;
      total_cnt_q <= '0;
      line_base_q <= base_addr_i;
    end else if (enable_i) begin
      total_cnt_q <= total_cnt_q + 1'b1;
      if (word_cnt_nxt == line_length_i) begin  // end of line
        word_cnt_q  <= '0;
        line_base_q <= line_base_q + line_stride_i;
      end else begin
        word_cnt_q <= word_cnt_nxt;
      end
    end
  end

  // the controller must stop stepping once the last beat is out
  a_no_enable_past_end : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    enable_i |-> in_progress_o
  );

endmodule

`default_nettype wire

// ==== hdl/stream_source_pkg.sv ====
/*
 * stream source package
 * controller state and TCDM word/address types
 */
`default_nettype none

`include "source_params.svh"

package stream_source_pkg;

  typedef enum logic {
    SRC_IDLE    = 1'b0,
    SRC_WORKING = 1'b1
  } source_state_e;

  typedef logic [`SRC_WORD_W-1:0] tcdm_word_t;
  typedef logic [`SRC_ADDR_W-1:0] tcdm_addr_t;  // byte address

endpackage

`default_nettype wire

// ==== include/source_params.svh ====
/*
 * stream source parameters
 * port count, word, address and counter widths shared by RTL and testbench
 */
`ifndef SOURCE_PARAMS_SVH
`define SOURCE_PARAMS_SVH

`define SRC_NB_PORTS  2
`define SRC_WORD_W    32
`define SRC_ADDR_W    32
`define SRC_CNT_W     16

// one stream beat carries one word per port
`define SRC_STREAM_W  (`SRC_NB_PORTS * `SRC_WORD_W)

`endif
